// File: rtl/l2c_data_stage.sv
`timescale 1ns/1ns

module l2c_data_stage #(
  parameter int WAYS     = 4,
  parameter int SET_BITS = 4
) (
  input  logic       forever_cpuclk,
  input  logic       rst_n,
  l2c_lookup_if.sink lookup,
  l2c_resp_if.source resp
);
  import l2c_pkg::*;

  localparam int SETS = 1 << SET_BITS;

  data_t data_arr [SETS][WAYS];

  logic  wr_en;
  data_t rd_word;

  assign wr_en = lookup.vld && (lookup.op == OP_WRITE);

  always_ff @(posedge forever_cpuclk) begin
    if (wr_en) begin
      data_arr[lookup.set][lookup.way] <= lookup.wdata;
    end
  end

  // Read miss returns zero
  always_comb begin
    if (lookup.hit) begin
      rd_word = data_arr[lookup.set][lookup.way];
    end else begin
      rd_word = '0;
    end
  end

  assign resp.vld  = lookup.vld;
  assign resp.sid  = lookup.sid;
  assign resp.resp = lookup.hit ? RESP_HIT : RESP_MISS;

  // Writes echo their own data
  assign resp.rdata = (lookup.op == OP_WRITE) ? lookup.wdata : rd_word;

endmodule

// File: rtl/l2c_lookup_if.sv
`timescale 1ns/1ns

interface l2c_lookup_if #(
  parameter int WAYS     = 4,
  parameter int SET_BITS = 4
);
  import l2c_pkg::*;

  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  // One cycle per looked-up request, no stall
  logic                vld;
  l2c_op_e             op;
  logic [SET_BITS-1:0] set;
  logic [WAY_BITS-1:0] way;
  logic                hit;
  sid_t                sid;
  data_t               wdata;

  modport source (output vld, op, set, way, hit, sid, wdata);
  modport sink   (input  vld, op, set, way, hit, sid, wdata);

endinterface

// File: rtl/l2c_pkg.sv
package l2c_pkg;

  // Request word address, line data and source id
  localparam int ADDR_WIDTH = 16;
  localparam int DATA_WIDTH = 32;
  localparam int SID_WIDTH  = 5;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [SID_WIDTH-1:0]  sid_t;

  // Request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } l2c_op_e;

  // Completion kind reported back to the requester
  typedef enum logic {
    RESP_HIT  = 1'b0,
    RESP_MISS = 1'b1
  } l2c_resp_e;

endpackage

// File: rtl/l2c_resp_ctrl.sv
`timescale 1ns/1ns

module l2c_resp_ctrl #(
  parameter int FIFO_DEPTH   = 4,
  parameter int RESP_CREDITS = 2
) (
  input  logic               forever_cpuclk,
  input  logic               rst_n,
  input  logic               req_vld,
  input  logic               resp_credit,
  l2c_resp_if.sink           resp,
  output logic               req_ready,
  output logic               req_accept,
  output logic               resp_vld,
  output l2c_pkg::sid_t      resp_sid,
  output l2c_pkg::l2c_resp_e resp_kind,
  output l2c_pkg::data_t     resp_data,
  output logic               l2c_no_op
);
  import l2c_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CRD_W = $clog2(RESP_CREDITS + 1);

  sid_t      fifo_sid  [FIFO_DEPTH];
  l2c_resp_e fifo_kind [FIFO_DEPTH];
  data_t     fifo_data [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  // Requests in the stages plus buffered responses
  logic [CNT_W-1:0] rsv_cnt;
  logic [CRD_W-1:0] credit_cnt;
  logic             send;

  assign req_ready  = rsv_cnt < CNT_W'(FIFO_DEPTH);
  assign req_accept = req_vld && req_ready;
  assign l2c_no_op  = rsv_cnt == '0;

  // Pop the head whenever the consumer has room
  assign send      = (fifo_cnt != '0) && (credit_cnt != '0);
  assign resp_vld  = send;
  assign resp_sid  = fifo_sid[rd_ptr];
  assign resp_kind = fifo_kind[rd_ptr];
  assign resp_data = fifo_data[rd_ptr];

  always_ff @(posedge forever_cpuclk) begin
    if (resp.vld) begin
      fifo_sid[wr_ptr]  <= resp.sid;
      fifo_kind[wr_ptr] <= resp.resp;
      fifo_data[wr_ptr] <= resp.rdata;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (resp.vld) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({resp.vld, send})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // Reservation taken at acceptance, freed when the response goes out
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      rsv_cnt <= '0;
    end else begin
      case ({req_accept, send})
        2'b10:   rsv_cnt <= rsv_cnt + 1'b1;
        2'b01:   rsv_cnt <= rsv_cnt - 1'b1;
        default: rsv_cnt <= rsv_cnt;
      endcase
    end
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      credit_cnt <= CRD_W'(RESP_CREDITS);
    end else begin
      case ({resp_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

// File: rtl/l2c_resp_if.sv
`timescale 1ns/1ns

interface l2c_resp_if;
  import l2c_pkg::*;

  // Finished access, pushed into the response FIFO
  logic      vld;
  sid_t      sid;
  l2c_resp_e resp;
  data_t     rdata;

  modport source (output vld, sid, resp, rdata);
  modport sink   (input  vld, sid, resp, rdata);

endinterface

// File: rtl/l2c_sub_bank.sv
`timescale 1ns/1ns

module l2c_sub_bank #(
  parameter int WAYS         = 4,
  parameter int SET_BITS     = 4,
  parameter int FIFO_DEPTH   = 4,
  parameter int RESP_CREDITS = 2
) (
  input  logic               forever_cpuclk,
  input  logic               rst_n,
  input  logic               req_vld,
  input  l2c_pkg::l2c_op_e   req_op,
  input  l2c_pkg::addr_t     req_addr,
  input  l2c_pkg::data_t     req_wdata,
  input  l2c_pkg::sid_t      req_sid,
  output logic               req_ready,
  output logic               resp_vld,
  output l2c_pkg::sid_t      resp_sid,
  output l2c_pkg::l2c_resp_e resp_kind,
  output l2c_pkg::data_t     resp_data,
  input  logic               resp_credit,
  output logic               l2c_no_op
);

  logic req_accept;

  l2c_lookup_if #(
    .WAYS     (WAYS),
    .SET_BITS (SET_BITS)
  ) l2c_lookup ();

  l2c_resp_if l2c_resp ();

  l2c_tag_stage #(
    .WAYS     (WAYS),
    .SET_BITS (SET_BITS)
  ) x_l2c_tag_stage (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .req_accept     (req_accept),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_sid        (req_sid),
    .lookup         (l2c_lookup.source)
  );

  l2c_data_stage #(
    .WAYS     (WAYS),
    .SET_BITS (SET_BITS)
  ) x_l2c_data_stage (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .lookup         (l2c_lookup.sink),
    .resp           (l2c_resp.source)
  );

  l2c_resp_ctrl #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .RESP_CREDITS (RESP_CREDITS)
  ) x_l2c_resp_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .req_vld        (req_vld),
    .resp_credit    (resp_credit),
    .resp           (l2c_resp.sink),
    .req_ready      (req_ready),
    .req_accept     (req_accept),
    .resp_vld       (resp_vld),
    .resp_sid       (resp_sid),
    .resp_kind      (resp_kind),
    .resp_data      (resp_data),
    .l2c_no_op      (l2c_no_op)
  );

endmodule

// File: rtl/l2c_tag_stage.sv
`timescale 1ns/1ns

module l2c_tag_stage #(
  parameter int WAYS     = 4,
  parameter int SET_BITS = 4
) (
  input  logic             forever_cpuclk,
  input  logic             rst_n,
  input  logic             req_accept,
  input  l2c_pkg::l2c_op_e req_op,
  input  l2c_pkg::addr_t   req_addr,
  input  l2c_pkg::data_t   req_wdata,
  input  l2c_pkg::sid_t    req_sid,
  l2c_lookup_if.source     lookup
);
  import l2c_pkg::*;

  localparam int SETS     = 1 << SET_BITS;
  localparam int TAG_BITS = ADDR_WIDTH - SET_BITS;
  localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

  // Request accepted at the previous edge
  logic    req_vld_q;
  l2c_op_e op_q;
  addr_t   addr_q;
  data_t   wdata_q;
  sid_t    sid_q;

  logic [TAG_BITS-1:0] tag_arr    [SETS][WAYS];
  logic [WAYS-1:0]     valid_arr  [SETS];
  logic [WAY_BITS-1:0] victim_ptr [SETS];

  logic [SET_BITS-1:0] cur_set;
  logic [TAG_BITS-1:0] cur_tag;
  logic [WAYS-1:0]     hit_vec;
  logic                hit;
  logic [WAY_BITS-1:0] hit_way;
  logic [WAY_BITS-1:0] way_sel;
  logic                alloc;

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= req_accept;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (req_accept) begin
      op_q    <= req_op;
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
      sid_q   <= req_sid;
    end
  end

  // Set index in the low bits, tag above it
  assign cur_set = addr_q[SET_BITS-1:0];
  assign cur_tag = addr_q[ADDR_WIDTH-1:SET_BITS];

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w] = valid_arr[cur_set][w] && (tag_arr[cur_set][w] == cur_tag);
    end
  end

  assign hit = |hit_vec;

  always_comb begin
    hit_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = WAY_BITS'(w);
      end
    end
  end

  // Write miss takes the round-robin victim and drops its old line
  assign alloc   = req_vld_q && (op_q == OP_WRITE) && !hit;
  assign way_sel = hit ? hit_way : victim_ptr[cur_set];

  always_ff @(posedge forever_cpuclk) begin
    if (alloc) begin
      tag_arr[cur_set][way_sel] <= cur_tag;
    end
  end

  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        valid_arr[s]  <= '0;
        victim_ptr[s] <= '0;
      end
    end else if (alloc) begin
      valid_arr[cur_set][way_sel] <= 1'b1;
      if (victim_ptr[cur_set] == WAY_BITS'(WAYS - 1)) begin
        victim_ptr[cur_set] <= '0;
      end else begin
        victim_ptr[cur_set] <= victim_ptr[cur_set] + 1'b1;
      end
    end
  end

  // Lookup result handed to the data stage
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      lookup.vld <= 1'b0;
    end else begin
      lookup.vld <= req_vld_q;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (req_vld_q) begin
      lookup.op    <= op_q;
      lookup.set   <= cur_set;
      lookup.way   <= way_sel;
      lookup.hit   <= hit;
      lookup.sid   <= sid_q;
      lookup.wdata <= wdata_q;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the L2 sub-bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sources.f --top-module tb_l2c_sub_bank -o sim_l2c_sub_bank
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_l2c_sub_bank
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit 1
fi

exit 0

// File: sources.f
rtl/l2c_pkg.sv
rtl/l2c_lookup_if.sv
rtl/l2c_resp_if.sv
rtl/l2c_tag_stage.sv
rtl/l2c_data_stage.sv
rtl/l2c_resp_ctrl.sv
rtl/l2c_sub_bank.sv
testbench/tb_l2c_sub_bank.sv

// File: testbench/tb_l2c_sub_bank.sv
`timescale 1ns/1ns

module tb_l2c_sub_bank;
  import l2c_pkg::*;

  localparam int WAYS         = 4;
  localparam int SET_BITS     = 4;
  localparam int FIFO_DEPTH   = 4;
  localparam int RESP_CREDITS = 2;
  localparam int SETS         = 1 << SET_BITS;
  localparam int TAG_BITS     = ADDR_WIDTH - SET_BITS;
  localparam int CLK_PERIOD   = 40;

  localparam int RAW_PAIRS      = 40;
  localparam int MISS_OPS       = 30;
  localparam int CREDIT_OPS     = 200;
  localparam int IDLE_OPS       = FIFO_DEPTH + RESP_CREDITS;
  localparam int TOTAL_OPS      = 2 * RAW_PAIRS + MISS_OPS + 2 * (WAYS + 1) + CREDIT_OPS
                                  + IDLE_OPS;
  // Margin covers reset and the phase with credits held back
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * 20 + 200;

  logic      forever_cpuclk;
  logic      rst_n;
  logic      req_vld;
  l2c_op_e   req_op;
  addr_t     req_addr;
  data_t     req_wdata;
  sid_t      req_sid;
  logic      req_ready;
  logic      resp_vld;
  sid_t      resp_sid;
  l2c_resp_e resp_kind;
  data_t     resp_data;
  logic      resp_credit = 1'b0;
  logic      l2c_no_op;

  // Cache model
  logic [TAG_BITS-1:0] m_tag   [SETS][WAYS];
  bit                  m_valid [SETS][WAYS];
  data_t               m_data  [SETS][WAYS];
  int                  m_ptr   [SETS];

  // Expected responses in acceptance order
  string     exp_name [$];
  sid_t      exp_sid  [$];
  l2c_resp_e exp_kind [$];
  data_t     exp_data [$];

  int    rsv_cnt     = 0;
  int    credit_cnt  = RESP_CREDITS;
  int    received    = 0;
  int    released    = 0;
  bit    withhold    = 1'b0;
  int    release_pct = 70;
  string test_name   = "reset";

  l2c_sub_bank #(
    .WAYS         (WAYS),
    .SET_BITS     (SET_BITS),
    .FIFO_DEPTH   (FIFO_DEPTH),
    .RESP_CREDITS (RESP_CREDITS)
  ) l2c_sub_bank_i (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .req_vld        (req_vld),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_sid        (req_sid),
    .req_ready      (req_ready),
    .resp_vld       (resp_vld),
    .resp_sid       (resp_sid),
    .resp_kind      (resp_kind),
    .resp_data      (resp_data),
    .resp_credit    (resp_credit),
    .l2c_no_op      (l2c_no_op)
  );

  initial begin
    forever_cpuclk = 1'b0;
    forever #(CLK_PERIOD / 2) forever_cpuclk = ~forever_cpuclk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired before all tests finished");
  end

  // Applies one access to the model, returns the expected response
  task automatic model_access(input l2c_op_e op, input addr_t addr, input data_t wdata,
                              output l2c_resp_e kind, output data_t rdata);
    int                  set_i;
    int                  way_i;
    logic [TAG_BITS-1:0] tag;
    bit                  hit;
    set_i = int'(addr[SET_BITS-1:0]);
    tag   = addr[ADDR_WIDTH-1:SET_BITS];
    hit   = 1'b0;
    way_i = 0;
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[set_i][w] && m_tag[set_i][w] == tag) begin
        hit   = 1'b1;
        way_i = w;
      end
    end
    kind = hit ? RESP_HIT : RESP_MISS;
    if (op == OP_READ) begin
      rdata = hit ? m_data[set_i][way_i] : '0;
    end else begin
      if (!hit) begin
        way_i                = m_ptr[set_i];
        m_tag[set_i][way_i]   = tag;
        m_valid[set_i][way_i] = 1'b1;
        m_ptr[set_i]          = (m_ptr[set_i] + 1) % WAYS;
      end
      m_data[set_i][way_i] = wdata;
      rdata                = wdata;
    end
  endtask

  // Runs mid-cycle, where every DUT output is settled
  task automatic check_cycle();
    string     name;
    l2c_resp_e kind;
    data_t     rdata;
    assert (req_ready == (rsv_cnt < FIFO_DEPTH))
      else abort_run($sformatf("req_ready wrong with %0d requests reserved", rsv_cnt));
    assert (l2c_no_op == (rsv_cnt == 0))
      else abort_run($sformatf("l2c_no_op wrong with %0d requests reserved", rsv_cnt));
    if (resp_vld) begin
      assert (credit_cnt > 0) else abort_run("resp_vld raised with no credit left");
      assert (exp_sid.size() > 0) else abort_run("Response with no request outstanding");
      name = exp_name.pop_front();
      assert (resp_sid == exp_sid[0])
        else abort_run($sformatf("Mismatch in test %s on sid: expected %0h, actual %0h",
                                 name, exp_sid[0], resp_sid));
      assert (resp_kind == exp_kind[0])
        else abort_run($sformatf("Mismatch in test %s on kind: expected %s, actual %s",
                                 name, exp_kind[0].name(), resp_kind.name()));
      assert (resp_data == exp_data[0])
        else abort_run($sformatf("Mismatch in test %s on data: expected %h, actual %h",
                                 name, exp_data[0], resp_data));
      void'(exp_sid.pop_front());
      void'(exp_kind.pop_front());
      void'(exp_data.pop_front());
      received++;
      assert (received - released <= RESP_CREDITS)
        else abort_run("Consumer holds more responses than it has buffer space");
      credit_cnt--;
      rsv_cnt--;
    end
    if (resp_credit) begin
      credit_cnt++;
    end
    if (req_vld && req_ready) begin
      model_access(req_op, req_addr, req_wdata, kind, rdata);
      exp_name.push_back(test_name);
      exp_sid.push_back(req_sid);
      exp_kind.push_back(kind);
      exp_data.push_back(rdata);
      rsv_cnt++;
    end
  endtask

  always @(negedge forever_cpuclk) begin
    if (rst_n) begin
      check_cycle();
    end
  end

  // Consumer frees buffered responses at random
  always @(posedge forever_cpuclk) begin
    if (rst_n && !withhold && received > released
        && int'($urandom_range(0, 99)) < release_pct) begin
      resp_credit <= 1'b1;
      released++;
    end else begin
      resp_credit <= 1'b0;
    end
  end

  // Few tags over few sets, so lines get hit, missed and evicted
  function automatic addr_t pool_addr();
    return addr_t'(int'($urandom_range(0, 5)) * SETS + int'($urandom_range(0, 2)));
  endfunction

  task automatic issue(input l2c_op_e op, input addr_t addr, input data_t wdata);
    @(posedge forever_cpuclk);
    req_vld   <= 1'b1;
    req_op    <= op;
    req_addr  <= addr;
    req_wdata <= wdata;
    req_sid   <= sid_t'($urandom);
    do @(negedge forever_cpuclk); while (!req_ready);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge forever_cpuclk);
      req_vld <= 1'b0;
    end
  endtask

  task automatic random_gap();
    if ($urandom_range(0, 3) == 0) begin
      idle_cycles(int'($urandom_range(1, 3)));
    end
  endtask

  task automatic drain();
    idle_cycles(1);
    while (rsv_cnt != 0) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    assert (l2c_no_op) else abort_run("l2c_no_op low after all responses drained");
  endtask

  initial begin
    addr_t addr;
    void'($urandom(32'hf0df));
    rst_n     = 1'b0;
    req_vld   = 1'b0;
    req_op    = OP_READ;
    req_addr  = '0;
    req_wdata = '0;
    req_sid   = '0;
    repeat (16) @(posedge forever_cpuclk);
    rst_n <= 1'b1;
    @(negedge forever_cpuclk);
    assert (l2c_no_op && req_ready && !resp_vld) else abort_run("Outputs not idle after reset");

    // Read issued on the cycle right after the write
    test_name = "raw";
    for (int i = 0; i < RAW_PAIRS; i++) begin
      addr = pool_addr();
      issue(OP_WRITE, addr, $urandom);
      issue(OP_READ, addr, '0);
      random_gap();
    end
    drain();

    test_name = "miss";
    for (int i = 0; i < MISS_OPS; i++) begin
      case (i % 3)
        0:       issue(OP_READ, addr_t'((64 + i) * SETS + i % 3), '0);
        1:       issue(OP_WRITE, addr_t'((128 + i) * SETS + i % 3), $urandom);
        default: issue(OP_READ, pool_addr(), '0);
      endcase
      random_gap();
    end
    drain();

    // Untouched set, so the oldest of WAYS+1 tags goes out
    test_name = "evict";
    for (int k = 0; k <= WAYS; k++) begin
      issue(OP_WRITE, addr_t'((200 + k) * SETS + SETS - 1), $urandom);
    end
    for (int k = 0; k <= WAYS; k++) begin
      issue(OP_READ, addr_t'((200 + k) * SETS + SETS - 1), '0);
    end
    drain();

    test_name   = "credit";
    release_pct = 25;
    for (int i = 0; i < CREDIT_OPS; i++) begin
      issue(($urandom_range(0, 1) == 0) ? OP_READ : OP_WRITE, pool_addr(), $urandom);
      random_gap();
    end
    drain();

    test_name   = "idle";
    release_pct = 70;
    wait (received == released);
    withhold = 1'b1;
    for (int i = 0; i < IDLE_OPS; i++) begin
      issue(($urandom_range(0, 1) == 0) ? OP_READ : OP_WRITE, pool_addr(), $urandom);
    end
    idle_cycles(4);
    @(negedge forever_cpuclk);
    assert (!req_ready) else abort_run("req_ready stayed high with every entry reserved");
    assert (!l2c_no_op) else abort_run("l2c_no_op high while requests are outstanding");
    withhold = 1'b0;
    while (!req_ready) @(negedge forever_cpuclk);
    drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule
